//--- design/xbar_pkg.sv
/*
 * Peripheral crossbar shared definitions
 * Port counts, bus widths, peripheral address map and handshake enums
 */
package xbar_pkg;

    ////////////////////////////////////////////////////////////
    // Port counts and bus widths
    ////////////////////////////////////////////////////////////
    localparam int N_MASTER   = 4;               // Master request ports
    localparam int N_SLAVE    = 4;               // Peripheral ports
    localparam int ADDR_WIDTH = 32;              // Master byte address
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;  // One enable per byte
    localparam int ID_WIDTH   = N_MASTER;        // One-hot master tag

    // Index of a master, used by the round-robin pointer
    localparam int MASTER_IDX_WIDTH = $clog2(N_MASTER);

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////
    // 4 KB peripheral window, matched on bits 31:12
    localparam logic [ADDR_WIDTH-1:0] PERIPH_BASE = 32'h1A10_0000;
    localparam int WINDOW_LSB = 12;

    // Slave select field inside the window
    localparam int ROUTE_LSB = 10;
    localparam int ROUTE_MSB = 11;

    // Word offset inside one slave, bits 9:2
    localparam int SLAVE_ADDR_WIDTH = 8;

    ////////////////////////////////////////////////////////////
    // Handshake encodings
    ////////////////////////////////////////////////////////////
    // Meaning of data_wen
    typedef enum logic {
        REQ_STORE = 1'b0,
        REQ_LOAD  = 1'b1
    } req_type_e;

    // Response opcode
    typedef enum logic {
        OPC_OK  = 1'b0,
        OPC_ERR = 1'b1
    } resp_opc_e;

endpackage

//--- design/master_router.sv
/*
 * Master router
 * Decodes one master address into a slave request, returns the grant
 * and picks this master's response out of all slave lanes
 */
`timescale 1ns/100ps

module master_router
(
    input  logic                                              clk,
    input  logic                                              reset_i,

    // Request from the master
    input  logic                                              data_req_i,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0]                  data_add_i,

    // Grant and response back to the master
    output logic                                              data_gnt_o,
    output logic                                              data_r_valid_o,
    output logic [xbar_pkg::DATA_WIDTH-1:0]                  data_r_rdata_o,
    output logic                                              data_r_opc_o,

    // One request bit per slave arbiter
    output logic [xbar_pkg::N_SLAVE-1:0]                     slave_req_o,
    // Grant and response-valid bits, one per slave arbiter
    input  logic [xbar_pkg::N_SLAVE-1:0]                     slave_gnt_i,
    input  logic [xbar_pkg::N_SLAVE-1:0]                     slave_r_valid_i,

    // Response lanes of every slave
    input  logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::DATA_WIDTH-1:0] data_r_rdata_i,
    input  logic [xbar_pkg::N_SLAVE-1:0]                     data_r_opc_i
);

    import xbar_pkg::*;

    logic                           in_window;    // Address hits the peripheral window
    logic [ROUTE_MSB-ROUTE_LSB:0]   route_sel;    // Target slave index
    logic                           out_req;      // Request outside the window
    logic                           err_pending;  // Error response due next cycle
    logic [DATA_WIDTH-1:0]          sel_rdata;
    resp_opc_e                      sel_opc;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    assign in_window = (data_add_i[ADDR_WIDTH-1:WINDOW_LSB] ==
                        PERIPH_BASE[ADDR_WIDTH-1:WINDOW_LSB]);
    assign route_sel = data_add_i[ROUTE_MSB:ROUTE_LSB];
    assign out_req   = data_req_i & ~in_window;

    // One-hot request toward the decoded slave, none when outside
    assign slave_req_o = (data_req_i && in_window) ? (N_SLAVE'(1) << route_sel) : '0;

    // Only the addressed arbiter can grant; local grant for bad addresses
    assign data_gnt_o = out_req | (|slave_gnt_i);

    ////////////////////////////////////////////////////////////
    // Error response
    ////////////////////////////////////////////////////////////
    // Granted in the request cycle, answered one cycle later
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            err_pending <= 1'b0;
        end
        else
        begin
            err_pending <= out_req;  // One-shot, master drops or changes req
        end
    end

    ////////////////////////////////////////////////////////////
    // Response select
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        sel_rdata = '0;
        sel_opc   = OPC_OK;
        // At most one slave names this master per cycle
        for (int s = 0; s < N_SLAVE; s++)
        begin
            if (slave_r_valid_i[s])
            begin
                sel_rdata = data_r_rdata_i[s];
                sel_opc   = resp_opc_e'(data_r_opc_i[s]);
            end
        end
    end

    assign data_r_valid_o = err_pending | (|slave_r_valid_i);
    assign data_r_rdata_o = err_pending ? '0 : sel_rdata;       // Zero data on error
    assign data_r_opc_o   = err_pending ? OPC_ERR : sel_opc;

endmodule

//--- design/slave_arbiter.sv
/*
 * Slave arbiter
 * Round-robin choice among the masters for one peripheral port, with
 * request mux, one-hot ID tagging and response-valid fan-out
 */
`timescale 1ns/100ps

module slave_arbiter
(
    input  logic                                                  clk,
    input  logic                                                  reset_i,

    // Request bits routed to this slave, one per master
    input  logic [xbar_pkg::N_MASTER-1:0]                        master_req_i,
    // Request fields of every master
    input  logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::ADDR_WIDTH-1:0] data_add_i,
    input  logic [xbar_pkg::N_MASTER-1:0]                        data_wen_i,
    input  logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::DATA_WIDTH-1:0] data_wdata_i,
    input  logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::BE_WIDTH-1:0]   data_be_i,
    // Grant back to the winning master
    output logic [xbar_pkg::N_MASTER-1:0]                        master_gnt_o,

    // Request toward the slave
    output logic                                                  data_req_o,
    output logic [xbar_pkg::SLAVE_ADDR_WIDTH-1:0]                data_add_o,
    output logic                                                  data_wen_o,
    output logic [xbar_pkg::DATA_WIDTH-1:0]                      data_wdata_o,
    output logic [xbar_pkg::BE_WIDTH-1:0]                        data_be_o,
    output logic [xbar_pkg::ID_WIDTH-1:0]                        data_id_o,
    input  logic                                                  data_gnt_i,

    // Response handshake from the slave
    input  logic                                                  data_r_valid_i,
    input  logic [xbar_pkg::ID_WIDTH-1:0]                        data_r_id_i,
    // Response valid, one bit per master
    output logic [xbar_pkg::N_MASTER-1:0]                        master_r_valid_o
);

    import xbar_pkg::*;

    logic [MASTER_IDX_WIDTH-1:0] rr_ptr;     // Highest priority master
    logic [MASTER_IDX_WIDTH-1:0] cand;       // Master under test in the scan
    logic [MASTER_IDX_WIDTH-1:0] win_idx;    // Chosen master
    logic                        found;
    logic                        handshake;  // Request accepted by the slave
    req_type_e                   win_type;

    ////////////////////////////////////////////////////////////
    // Round-robin selection
    ////////////////////////////////////////////////////////////
    // First requester at or after the pointer, wrapping around
    always_comb
    begin
        found   = 1'b0;
        win_idx = rr_ptr;
        cand    = rr_ptr;
        for (int i = 0; i < N_MASTER; i++)
        begin
            cand = MASTER_IDX_WIDTH'((int'(rr_ptr) + i) % N_MASTER);
            if (!found && master_req_i[cand])
            begin
                found   = 1'b1;
                win_idx = cand;
            end
        end
    end

    assign handshake = found & data_gnt_i;

    // Pointer moves one past the winner, only on an accepted request
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            rr_ptr <= '0;
        end
        else if (handshake)
        begin
            if (win_idx == MASTER_IDX_WIDTH'(N_MASTER - 1))
                rr_ptr <= '0;
            else
                rr_ptr <= win_idx + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request mux toward the slave
    ////////////////////////////////////////////////////////////
    assign win_type     = req_type_e'(data_wen_i[win_idx]);
    assign data_req_o   = found;
    // Word offset, bits just below the route field
    assign data_add_o   = data_add_i[win_idx][ROUTE_LSB-1 -: SLAVE_ADDR_WIDTH];
    assign data_wen_o   = win_type;
    assign data_wdata_o = data_wdata_i[win_idx];
    assign data_be_o    = data_be_i[win_idx];
    assign data_id_o    = found ? (ID_WIDTH'(1) << win_idx) : '0;  // One-hot tag

    // Slave grant reaches the winner only
    assign master_gnt_o = handshake ? (N_MASTER'(1) << win_idx) : '0;

    ////////////////////////////////////////////////////////////
    // Response valid fan-out
    ////////////////////////////////////////////////////////////
    assign master_r_valid_o = data_r_valid_i ? data_r_id_i : '0;  // ID bit names the master

endmodule

//--- design/periph_xbar.sv
/*
 * Peripheral crossbar top
 * Router per master, arbiter per slave, cross-wired by matrix transposes
 */
`timescale 1ns/100ps

module periph_xbar
(
    input  logic                                                     clk,
    input  logic                                                     reset_i,

    // Master side requests
    input  logic [xbar_pkg::N_MASTER-1:0]                           data_req_i,
    input  logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::ADDR_WIDTH-1:0] data_add_i,
    input  logic [xbar_pkg::N_MASTER-1:0]                           data_wen_i,
    input  logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::DATA_WIDTH-1:0] data_wdata_i,
    input  logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::BE_WIDTH-1:0]   data_be_i,
    output logic [xbar_pkg::N_MASTER-1:0]                           data_gnt_o,
    // Master side responses
    output logic [xbar_pkg::N_MASTER-1:0]                           data_r_valid_o,
    output logic [xbar_pkg::N_MASTER-1:0][xbar_pkg::DATA_WIDTH-1:0] data_r_rdata_o,
    output logic [xbar_pkg::N_MASTER-1:0]                           data_r_opc_o,

    // Slave side requests
    output logic [xbar_pkg::N_SLAVE-1:0]                            data_req_o,
    output logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::SLAVE_ADDR_WIDTH-1:0] data_add_o,
    output logic [xbar_pkg::N_SLAVE-1:0]                            data_wen_o,
    output logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::DATA_WIDTH-1:0]  data_wdata_o,
    output logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::BE_WIDTH-1:0]    data_be_o,
    output logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::ID_WIDTH-1:0]    data_id_o,
    input  logic [xbar_pkg::N_SLAVE-1:0]                            data_gnt_i,
    // Slave side responses
    input  logic [xbar_pkg::N_SLAVE-1:0]                            data_r_valid_i,
    input  logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::DATA_WIDTH-1:0]  data_r_rdata_i,
    input  logic [xbar_pkg::N_SLAVE-1:0][xbar_pkg::ID_WIDTH-1:0]    data_r_id_i,
    input  logic [xbar_pkg::N_SLAVE-1:0]                            data_r_opc_i
);

    import xbar_pkg::*;

    // Router view, indexed [master][slave]
    logic [N_MASTER-1:0][N_SLAVE-1:0] req_from_master;
    logic [N_MASTER-1:0][N_SLAVE-1:0] gnt_to_master;
    logic [N_MASTER-1:0][N_SLAVE-1:0] r_valid_to_master;

    // Arbiter view, indexed [slave][master]
    logic [N_SLAVE-1:0][N_MASTER-1:0] req_to_slave;
    logic [N_SLAVE-1:0][N_MASTER-1:0] gnt_from_slave;
    logic [N_SLAVE-1:0][N_MASTER-1:0] r_valid_from_slave;

    ////////////////////////////////////////////////////////////
    // Matrix transposes
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_transpose_m
        for (genvar s = 0; s < N_SLAVE; s++)
        begin : g_transpose_s
            assign req_to_slave[s][m]      = req_from_master[m][s];     // Request forward
            assign gnt_to_master[m][s]     = gnt_from_slave[s][m];      // Grant back
            assign r_valid_to_master[m][s] = r_valid_from_slave[s][m];  // Valid back
        end
    end

    ////////////////////////////////////////////////////////////
    // Master side routers
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_router
        master_router i_master_router
        (
            .clk             ( clk                  ),
            .reset_i         ( reset_i              ),
            .data_req_i      ( data_req_i[m]        ),
            .data_add_i      ( data_add_i[m]        ),
            .data_gnt_o      ( data_gnt_o[m]        ),
            .data_r_valid_o  ( data_r_valid_o[m]    ),
            .data_r_rdata_o  ( data_r_rdata_o[m]    ),
            .data_r_opc_o    ( data_r_opc_o[m]      ),
            .slave_req_o     ( req_from_master[m]   ),
            .slave_gnt_i     ( gnt_to_master[m]     ),
            .slave_r_valid_i ( r_valid_to_master[m] ),
            .data_r_rdata_i  ( data_r_rdata_i       ),  // All lanes, router picks one
            .data_r_opc_i    ( data_r_opc_i         )
        );
    end

    ////////////////////////////////////////////////////////////
    // Slave side arbiters
    ////////////////////////////////////////////////////////////
    for (genvar s = 0; s < N_SLAVE; s++)
    begin : g_arbiter
        slave_arbiter i_slave_arbiter
        (
            .clk              ( clk                   ),
            .reset_i          ( reset_i               ),
            .master_req_i     ( req_to_slave[s]       ),
            .data_add_i       ( data_add_i            ),  // Full buses of all masters
            .data_wen_i       ( data_wen_i            ),
            .data_wdata_i     ( data_wdata_i          ),
            .data_be_i        ( data_be_i             ),
            .master_gnt_o     ( gnt_from_slave[s]     ),
            .data_req_o       ( data_req_o[s]         ),
            .data_add_o       ( data_add_o[s]         ),
            .data_wen_o       ( data_wen_o[s]         ),
            .data_wdata_o     ( data_wdata_o[s]       ),
            .data_be_o        ( data_be_o[s]          ),
            .data_id_o        ( data_id_o[s]          ),
            .data_gnt_i       ( data_gnt_i[s]         ),
            .data_r_valid_i   ( data_r_valid_i[s]     ),
            .data_r_id_i      ( data_r_id_i[s]        ),
            .master_r_valid_o ( r_valid_from_slave[s] )
        );
    end

endmodule

//--- tb/tb_periph_xbar.sv
/*
 * Peripheral crossbar testbench
 * Stim-file driven masters against slave memory models with random grant stalls
 */
`timescale 1ns/100ps

module tb_periph_xbar;

    import xbar_pkg::*;

    localparam int MEM_DEPTH    = 256;
    localparam int WAVE_TIMEOUT = 200;  // Cycles allowed per wave
    localparam int RST_CYCLES   = 4;

    logic clk;
    logic reset_i;
    // Master side
    logic [N_MASTER-1:0]                 data_req_i;
    logic [N_MASTER-1:0][ADDR_WIDTH-1:0] data_add_i;
    logic [N_MASTER-1:0]                 data_wen_i;
    logic [N_MASTER-1:0][DATA_WIDTH-1:0] data_wdata_i;
    logic [N_MASTER-1:0][BE_WIDTH-1:0]   data_be_i;
    logic [N_MASTER-1:0]                 data_gnt_o;
    logic [N_MASTER-1:0]                 data_r_valid_o;
    logic [N_MASTER-1:0][DATA_WIDTH-1:0] data_r_rdata_o;
    logic [N_MASTER-1:0]                 data_r_opc_o;
    // Slave side
    logic [N_SLAVE-1:0]                       data_req_o;
    logic [N_SLAVE-1:0][SLAVE_ADDR_WIDTH-1:0] data_add_o;
    logic [N_SLAVE-1:0]                       data_wen_o;
    logic [N_SLAVE-1:0][DATA_WIDTH-1:0]       data_wdata_o;
    logic [N_SLAVE-1:0][BE_WIDTH-1:0]         data_be_o;
    logic [N_SLAVE-1:0][ID_WIDTH-1:0]         data_id_o;
    logic [N_SLAVE-1:0]                       data_gnt_i;
    logic [N_SLAVE-1:0]                       data_r_valid_i;
    logic [N_SLAVE-1:0][DATA_WIDTH-1:0]       data_r_rdata_i;
    logic [N_SLAVE-1:0][ID_WIDTH-1:0]         data_r_id_i;
    logic [N_SLAVE-1:0]                       data_r_opc_i;

    // Slave memories, grant LFSR and stim lines
    logic [DATA_WIDTH-1:0] mem [N_SLAVE][MEM_DEPTH];
    logic [31:0]           lfsr;
    int                    st_wave [$];
    string                 st_line [$];

    // Per-master state of the current wave
    logic [N_MASTER-1:0]   granted;
    logic [N_MASTER-1:0]   done;
    logic [N_MASTER-1:0]   err_due;  // Error answer expected next cycle
    logic [DATA_WIDTH-1:0] exp_rdata [N_MASTER];
    logic                  exp_opc [N_MASTER];

    periph_xbar i_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Slave hit by an address or -1 outside the 4 KB window at 1A10_0000
    function automatic int target_slave(input logic [ADDR_WIDTH-1:0] addr);
        if (addr[31:12] != 20'h1A100)
            return -1;
        return int'(addr[11:10]);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // Slave models
    ////////////////////////////////////////////////////////////
    initial
    begin
        logic [N_SLAVE-1:0]    rsp_pend;
        logic [DATA_WIDTH-1:0] rsp_data [N_SLAVE];
        logic [ID_WIDTH-1:0]   rsp_id [N_SLAVE];
        data_gnt_i     = '0;
        data_r_valid_i = '0;
        data_r_rdata_i = '0;
        data_r_id_i    = '0;
        data_r_opc_i   = '0;
        lfsr           = 32'h38d904b3;
        foreach (mem[s, a])
            mem[s][a] = '0;
        forever
        begin
            @(negedge clk);
            for (int s = 0; s < N_SLAVE; s++)
            begin
                rsp_pend[s] = data_req_o[s] & data_gnt_i[s];  // Handshake this cycle
                rsp_id[s]   = data_id_o[s];                   // Echoed back
                rsp_data[s] = mem[s][data_add_o[s]];
                if (rsp_pend[s] && data_wen_o[s] == REQ_STORE)
                begin
                    for (int b = 0; b < BE_WIDTH; b++)
                        if (data_be_o[s][b])
                            mem[s][data_add_o[s]][8*b +: 8] = data_wdata_o[s][8*b +: 8];
                    rsp_data[s] = '0;  // Stores answer with zero data
                end
            end
            @(posedge clk);
            #2;
            for (int s = 0; s < N_SLAVE; s++)
            begin
                data_r_valid_i[s] = rsp_pend[s];  // One cycle after the handshake
                data_r_id_i[s]    = rsp_id[s];
                data_r_rdata_i[s] = rsp_data[s];
                data_r_opc_i[s]   = OPC_OK;
                lfsr              = lfsr_step(lfsr);
                data_gnt_i[s]     = lfsr[0];      // Random stall
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Per-cycle checks sampled mid-cycle
    ////////////////////////////////////////////////////////////
    task automatic monitor_cycle();
        int                  m;
        logic [N_MASTER-1:0] exp_valid;
        exp_valid = err_due;  // Error answers come one cycle after their grant
        for (int s = 0; s < N_SLAVE; s++)
        begin
            if (data_req_o[s])
            begin
                check_value($sformatf("data_id_o[%0d] one-hot", s),
                            32'($onehot(data_id_o[s])), 32'd1);
                m = 0;
                for (int i = 0; i < N_MASTER; i++)
                    if (data_id_o[s][i])
                        m = i;
                if (!data_req_i[m] || target_slave(data_add_i[m]) != s)
                    fail_run($sformatf("Slave %0d sees a request master %0d did not send it",
                                       s, m));
                check_value($sformatf("data_add_o[%0d]", s), 32'(data_add_o[s]),
                            32'(data_add_i[m][9:2]));
                check_value($sformatf("data_wen_o[%0d]", s), 32'(data_wen_o[s]),
                            32'(data_wen_i[m]));
                check_value($sformatf("data_wdata_o[%0d]", s), data_wdata_o[s], data_wdata_i[m]);
                check_value($sformatf("data_be_o[%0d]", s), 32'(data_be_o[s]), 32'(data_be_i[m]));
            end
            // Slave response goes only to the master named by its ID
            if (data_r_valid_i[s])
                exp_valid = exp_valid | data_r_id_i[s];
        end
        check_value("data_r_valid_o", 32'(data_r_valid_o), 32'(exp_valid));
        for (int i = 0; i < N_MASTER; i++)
        begin
            if (data_gnt_o[i] && !data_req_i[i])
                fail_run($sformatf("Master %0d was granted without a request", i));
            // Out-of-window requests never wait
            if (data_req_i[i] && target_slave(data_add_i[i]) < 0 && !data_gnt_o[i])
                fail_run($sformatf("Master %0d out-of-window request not granted at once", i));
            if (data_r_valid_o[i])
            begin
                if (!granted[i] || done[i])
                    fail_run($sformatf("Master %0d got a response with no granted request", i));
                check_value($sformatf("data_r_rdata_o[%0d]", i), data_r_rdata_o[i], exp_rdata[i]);
                check_value($sformatf("data_r_opc_o[%0d]", i), 32'(data_r_opc_o[i]),
                            32'(exp_opc[i]));
                done[i] = 1'b1;
            end
            if (data_gnt_o[i])
                granted[i] = 1'b1;  // Response may follow from next cycle on
            err_due[i] = data_gnt_o[i] && target_slave(data_add_i[i]) < 0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stim driver
    ////////////////////////////////////////////////////////////
    initial
    begin
        int                  fd;
        int                  i;
        int                  first;
        int                  cycles;
        int                  rc;
        int                  wv;
        int                  m;
        int                  wen;
        int                  opc;
        string               line;
        logic [31:0]         addr;
        logic [31:0]         wdata;
        logic [31:0]         be;
        logic [31:0]         rdata;
        logic [N_MASTER-1:0] wave_mask;
        reset_i      = 1'b1;
        data_req_i   = '0;
        data_add_i   = '0;
        data_wen_i   = '0;
        data_wdata_i = '0;
        data_be_i    = '0;
        granted      = '0;
        done         = '0;
        err_due      = '0;

        fd = $fopen("tb/xbar_stim.txt", "r");
        if (fd == 0)
            fail_run("Cannot open the stim file tb/xbar_stim.txt");
        while ($fgets(line, fd) > 0)
        begin
            if (line.getc(0) != "#" && $sscanf(line, "%d", wv) == 1)  // Skip comments
            begin
                st_wave.push_back(wv);
                st_line.push_back(line);
            end
        end
        $fclose(fd);

        repeat (RST_CYCLES) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        check_value("data_req_o", 32'(data_req_o), 32'd0);  // Idle after reset
        check_value("data_r_valid_o", 32'(data_r_valid_o), 32'd0);

        i = 0;
        while (i < st_wave.size())
        begin
            first     = i;
            wave_mask = '0;
            granted   = '0;
            done      = '0;
            err_due   = '0;
            @(posedge clk);
            #2;
            // All lines of one wave go out together
            while (i < st_wave.size() && st_wave[i] == st_wave[first])
            begin
                rc = $sscanf(st_line[i], "%d %d %d %h %h %h %h %d",
                             wv, m, wen, addr, wdata, be, rdata, opc);
                if (rc != 8 || m < 0 || m >= N_MASTER || wave_mask[m])
                    fail_run($sformatf("Bad stim line %0d in wave %0d", i, st_wave[first]));
                wave_mask[m]    = 1'b1;
                data_req_i[m]   = 1'b1;
                data_wen_i[m]   = wen[0];
                data_add_i[m]   = addr;
                data_wdata_i[m] = wdata;
                data_be_i[m]    = be[BE_WIDTH-1:0];
                exp_rdata[m]    = rdata;
                exp_opc[m]      = opc[0];
                i++;
            end
            cycles = 0;
            while ((wave_mask & ~done) != '0)
            begin
                @(negedge clk);
                monitor_cycle();
                cycles++;
                if ((wave_mask & ~done) != '0 && cycles >= WAVE_TIMEOUT)
                    fail_run($sformatf("Timeout: wave %0d not complete after %0d cycles",
                                       st_wave[first], cycles));
                @(posedge clk);
                #2;
                data_req_i = data_req_i & ~granted;  // Hold until granted
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- project.f
design/xbar_pkg.sv
design/master_router.sv
design/slave_arbiter.sv
design/periph_xbar.sv
tb/tb_periph_xbar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator, run it, and decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_periph_xbar -f project.f -o tb_periph_xbar \
    && ./obj_dir/tb_periph_xbar | tee sim.log \
    && grep -qx "TEST OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/xbar_stim.txt
# wave master type(0 store, 1 load) addr wdata be exp_rdata exp_opc(0 ok, 1 err)
# addr, wdata, be and exp_rdata in hex; lines of one wave issue together
1 0 0 1A100004 11111111 F 00000000 0
1 1 0 1A100408 22222222 F 00000000 0
1 2 0 1A10080C 33333333 F 00000000 0
1 3 0 1A100C10 44444444 F 00000000 0
2 0 1 1A100C10 00000000 F 44444444 0
2 1 1 1A100004 00000000 F 11111111 0
2 2 1 1A100408 00000000 F 22222222 0
2 3 1 1A10080C 00000000 F 33333333 0
3 0 0 1A100820 AABBCCDD 3 00000000 0
3 1 0 1A100824 12345678 C 00000000 0
3 2 0 1A100828 55667788 5 00000000 0
3 3 1 1A10080C 00000000 F 33333333 0
4 0 1 1A100820 00000000 F 0000CCDD 0
4 1 1 1A100824 00000000 F 12340000 0
4 2 1 1A100828 00000000 F 00660088 0
4 3 1 1A101000 00000000 F 00000000 1
5 0 0 1A100820 FF000000 8 00000000 0
5 1 0 00000010 CAFEF00D F 00000000 1
6 2 1 1A100820 00000000 F FF00CCDD 0
6 3 1 1A1007FC 00000000 F 00000000 0
